// ==== hyper_pkg.sv ====
package hyper_pkg;

  // ----------------------------------------------------------
  // Bus widths and beat counts
  // ----------------------------------------------------------
  localparam int DQ_W            = 8;
  localparam int DWORD_W         = 32;
  localparam int BYTES_PER_DWORD = 4;
  localparam int REG_WR_BYTES    = 2;
  localparam int CA_BYTES        = 6;
  localparam int CA_W            = CA_BYTES * DQ_W;

  // Core cycles held off after reset (tRH)
  localparam int RESET_WAIT      = 30;
  // Read wait reload, the real end comes from RWDS strobing
  localparam int READ_WAIT_MAX   = 63;
  localparam int LAT_W           = 6;
  localparam int NUM_DWORDS_W    = 6;

  // Counter widths
  localparam int RST_CNT_W       = $clog2(RESET_WAIT + 1);
  localparam int CA_CNT_W        = $clog2(CA_BYTES + 1);
  localparam int DATA_CNT_W      = $clog2(BYTES_PER_DWORD + 1);

  // ----------------------------------------------------------
  // Host address, one word seen two ways
  // ----------------------------------------------------------
  // Memory space: byte address of a dword, A31 unused
  typedef struct packed {
    logic        rsvd;
    logic [28:0] row;
    logic [1:0]  col;
  } mem_addr_t;

  // Register space: 16-bit register index, e.g. 0x800 is CR0
  typedef struct packed {
    logic [28:0] row;
    logic [2:0]  col;
  } reg_addr_t;

  typedef union packed {
    mem_addr_t mem_view;
    reg_addr_t reg_view;
  } host_addr_u;

  // ----------------------------------------------------------
  // Core side
  // ----------------------------------------------------------
  typedef struct packed {
    logic                       rd;
    logic                       wr;
    logic                       reg_space;
    logic [BYTES_PER_DWORD-1:0] byte_en;
    logic [NUM_DWORDS_W-1:0]    num_dwords;
    host_addr_u                 addr;
    logic [DWORD_W-1:0]         wr_d;
  } host_req_t;

  typedef struct packed {
    logic               rdy;
    logic [DWORD_W-1:0] data;
  } rd_resp_t;

  // ----------------------------------------------------------
  // DRAM pin side
  // ----------------------------------------------------------
  typedef struct packed {
    logic [DQ_W-1:0] dq;
    logic            dq_oe_l;
    logic            rwds;
    logic            rwds_oe_l;
    logic            ck;
    logic            cs_l;
  } dram_out_t;

  typedef struct packed {
    logic [DQ_W-1:0] dq;
    logic            rwds;
  } dram_in_t;

  // Sequencer to pad stage, one cycle ahead of the pins
  typedef struct packed {
    logic [DQ_W-1:0] dq_byte;
    logic            mask;      // byte write enable, RWDS carries its inverse
    logic            dq_oe_l;
    logic            rwds_oe_l;
    logic            ck_phase;
    logic            cs;
  } seq_drive_t;

endpackage

// ==== hyper_cmd_seq.sv ====
`timescale 1ns/100ps

module hyper_cmd_seq import hyper_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  host_req_t  req,
  input  logic [7:0] latency_1x,
  input  logic [7:0] latency_2x,
  input  logic       rwds_q,
  input  logic       dword_done,
  output logic       busy,
  output logic       run_rd,
  output seq_drive_t drive
);

  // Latched transaction
  logic                       rw_bit;
  logic                       reg_bit;
  logic [CA_W-1:0]            ca_word;
  logic [CA_W-1:0]            addr_sr;
  logic [DWORD_W-1:0]         data_sr;
  logic [BYTES_PER_DWORD-1:0] be_sr;
  logic [NUM_DWORDS_W-1:0]    dwords_cnt;

  // Sequencing state
  logic                       accept;
  logic                       go;
  logic                       run;
  logic [1:0]                 run_sr;
  logic [1:0]                 ck_phs;
  logic [RST_CNT_W-1:0]       rst_cnt;
  logic [CA_CNT_W-1:0]        addr_cnt;
  logic [LAT_W-1:0]           wait_cnt;
  logic [DATA_CNT_W-1:0]      data_cnt;
  logic [LAT_W-1:0]           lat_sel;
  logic                       addr_beat;
  logic                       wait_beat;
  logic                       data_beat;

  // Registered pin drive
  logic [DQ_W-1:0]            sr_data;
  logic                       byte_wr_en;
  logic                       dq_oe_l;
  logic                       rwds_oe_l;
  logic                       cs_loc;

  // ----------------------------------------------------------
  // Command-address word
  // ----------------------------------------------------------
  // 47 R/W#, 46 address space, 45 linear burst, 15:3 reserved
  always_comb begin
    ca_word     = '0;
    ca_word[47] = req.rd;
    ca_word[46] = req.reg_space;
    ca_word[45] = 1'b1;
    if (req.reg_space) begin
      ca_word[44:16] = req.addr.reg_view.row;
      ca_word[2:0]   = req.addr.reg_view.col;
    end else begin
      // Always a dword, so half-word column LSB is zero
      ca_word[44:16] = req.addr.mem_view.row;
      ca_word[2:0]   = {req.addr.mem_view.col, 1'b0};
    end
  end

  assign accept = !busy && (req.rd || req.wr);

  // One beat per DRAM clock edge, every other core cycle
  assign addr_beat = ck_phs[0] && (addr_cnt != '0);
  assign wait_beat = ck_phs[0] && (addr_cnt == '0) && (wait_cnt != '0);
  assign data_beat = ck_phs[0] && (addr_cnt == '0) && (wait_cnt == '0) && (data_cnt != '0);

  // RWDS high during CA means the device wants 2x latency
  assign lat_sel = rwds_q ? latency_2x[LAT_W-1:0] : latency_1x[LAT_W-1:0];

  // ----------------------------------------------------------
  // Shift registers for CA, write data and byte enables
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      rw_bit     <= req.rd;
      reg_bit    <= req.reg_space;
      addr_sr    <= ca_word;
      data_sr    <= req.wr_d;
      be_sr      <= req.byte_en;
      dwords_cnt <= req.num_dwords;
    end else begin
      if (addr_beat) begin
        sr_data <= addr_sr[CA_W-1 -: DQ_W];
        addr_sr <= {addr_sr[CA_W-DQ_W-1:0], {DQ_W{1'b0}}};
      end
      // MSB first, register writes only use the top two bytes
      if (data_beat) begin
        sr_data <= data_sr[DWORD_W-1 -: DQ_W];
        data_sr <= {data_sr[DWORD_W-DQ_W-1:0], {DQ_W{1'b0}}};
        be_sr   <= {be_sr[BYTES_PER_DWORD-2:0], 1'b0};
      end
      if (dword_done) begin
        dwords_cnt <= dwords_cnt - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Control FSM: reset wait, CA, latency, data, CS release
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      go         <= 1'b0;
      run        <= 1'b0;
      run_rd     <= 1'b0;
      run_sr     <= 2'b00;
      ck_phs     <= 2'd0;
      rst_cnt    <= RST_CNT_W'(RESET_WAIT);
      addr_cnt   <= '0;
      wait_cnt   <= '0;
      data_cnt   <= '0;
      byte_wr_en <= 1'b0;
      dq_oe_l    <= 1'b1;
      rwds_oe_l  <= 1'b1;
      cs_loc     <= 1'b0;
    end else begin
      busy   <= go | run | cs_loc;
      run_sr <= {run_sr[0], run};
      ck_phs <= run ? ck_phs + 2'd1 : 2'd0;
      if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      if (accept) begin
        go   <= 1'b1;
        busy <= 1'b1;
      end

      // CA beats, DQ out and RWDS in
      if (addr_beat) begin
        dq_oe_l   <= 1'b0;
        rwds_oe_l <= 1'b1;
        addr_cnt  <= addr_cnt - 1'b1;
        if (addr_cnt == CA_CNT_W'(1)) begin
          if (rw_bit) begin
            wait_cnt <= LAT_W'(READ_WAIT_MAX);
            run_rd   <= 1'b1;
          end else if (reg_bit) begin
            // Register writes have zero latency
            data_cnt <= DATA_CNT_W'(REG_WR_BYTES);
          end else begin
            wait_cnt <= lat_sel;
          end
        end
      end

      if (wait_beat) begin
        wait_cnt   <= wait_cnt - 1'b1;
        byte_wr_en <= 1'b0;
        if (wait_cnt == LAT_W'(1)) begin
          data_cnt <= DATA_CNT_W'(BYTES_PER_DWORD);
        end
      end

      if (data_beat) begin
        data_cnt   <= data_cnt - 1'b1;
        byte_wr_en <= be_sr[BYTES_PER_DWORD-1];
        if (data_cnt == DATA_CNT_W'(1)) begin
          run    <= 1'b0;
          run_rd <= 1'b0;
        end
      end

      // Reads let go of both, register writes leave RWDS alone
      if (wait_beat || data_beat) begin
        dq_oe_l   <= rw_bit;
        rwds_oe_l <= rw_bit | reg_bit;
      end

      // Each captured dword rearms the read timeout
      if (dword_done) begin
        if (dwords_cnt > NUM_DWORDS_W'(1)) begin
          wait_cnt <= LAT_W'(READ_WAIT_MAX);
        end else begin
          run      <= 1'b0;
          run_rd   <= 1'b0;
          wait_cnt <= '0;
        end
      end

      // Kick off once the power-on wait has expired
      if (go && (rst_cnt == '0)) begin
        go        <= 1'b0;
        run       <= 1'b1;
        addr_cnt  <= CA_CNT_W'(CA_BYTES);
        wait_cnt  <= '0;
        data_cnt  <= '0;
        dq_oe_l   <= 1'b1;
        rwds_oe_l <= 1'b1;
      end

      // CS trails run by two cycles so the last edge lands
      if (run) begin
        cs_loc <= 1'b1;
      end else if (run_sr == 2'b00) begin
        cs_loc    <= 1'b0;
        dq_oe_l   <= 1'b1;
        rwds_oe_l <= 1'b1;
      end
    end
  end

  assign drive.dq_byte   = sr_data;
  assign drive.mask      = byte_wr_en;
  assign drive.dq_oe_l   = dq_oe_l;
  assign drive.rwds_oe_l = rwds_oe_l;
  assign drive.ck_phase  = ck_phs[1];
  assign drive.cs        = cs_loc;

  // Host side strobes
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(req.rd && req.wr));
  a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
    busy |-> !(req.rd || req.wr));

endmodule

// ==== hyper_rd_capture.sv ====
`timescale 1ns/100ps

module hyper_rd_capture import hyper_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            run_rd,
  input  logic            rwds_q,
  input  logic [DQ_W-1:0] dq_q,
  output logic            dword_done,
  output rd_resp_t        resp
);

  logic                       rwds_p1;
  logic                       hunt;
  logic                       gap;
  logic                       sample_now;
  logic [1:0]                 byte_cnt;
  logic [DWORD_W-DQ_W-1:0]    rd_sr;
  logic                       done_q;
  logic [DWORD_W-1:0]         data_q;

  // ----------------------------------------------------------
  // RWDS edge hunt, two samples per rising edge
  // ----------------------------------------------------------
  // Rise marks the first byte, falling half lands two cycles on
  always_ff @(posedge clk) begin
    rwds_p1 <= rwds_q;
    if (reset) begin
      hunt       <= 1'b1;
      gap        <= 1'b0;
      sample_now <= 1'b0;
      byte_cnt   <= 2'd0;
      done_q     <= 1'b0;
    end else begin
      sample_now <= 1'b0;
      done_q     <= 1'b0;
      if (!run_rd) begin
        hunt     <= 1'b1;
        gap      <= 1'b0;
        byte_cnt <= 2'd0;
      end else if (hunt) begin
        if (rwds_q && !rwds_p1) begin
          hunt       <= 1'b0;
          sample_now <= 1'b1;
        end
      end else begin
        gap <= ~gap;
        if (gap) begin
          hunt       <= 1'b1;
          sample_now <= 1'b1;
        end
      end

      // Four bytes make a dword
      if (sample_now && run_rd) begin
        byte_cnt <= byte_cnt + 2'd1;
        if (byte_cnt == 2'(BYTES_PER_DWORD - 1)) begin
          done_q <= 1'b1;
        end
      end
    end
  end

  // First byte ends up in the top lane
  always_ff @(posedge clk) begin
    if (sample_now && run_rd) begin
      rd_sr  <= {rd_sr[DWORD_W-2*DQ_W-1:0], dq_q};
      data_q <= {rd_sr, dq_q};
    end
  end

  assign dword_done = done_q;
  assign resp.rdy   = done_q;
  assign resp.data  = data_q;

  // Sequencer still holds run_rd when the dword lands
  a_done_in_read: assert property (@(posedge clk) disable iff (reset)
    dword_done |-> run_rd);

endmodule

// ==== hyper_pad_stage.sv ====
`timescale 1ns/100ps

module hyper_pad_stage import hyper_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  seq_drive_t      drive,
  input  dram_in_t        pins_in,
  output dram_out_t       pins_out,
  output logic            rwds_q,
  output logic [DQ_W-1:0] dq_q
);

  // Extra stage on the clock gives the 90 degree offset to DQ
  logic ck_loc;

  // ----------------------------------------------------------
  // IO flops
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    pins_out.dq   <= drive.dq_byte;
    // RWDS is a mask on writes, high means skip the byte
    pins_out.rwds <= ~drive.mask;
    rwds_q        <= pins_in.rwds;
    dq_q          <= pins_in.dq;
    if (reset) begin
      ck_loc             <= 1'b0;
      pins_out.ck        <= 1'b0;
      pins_out.dq_oe_l   <= 1'b1;
      pins_out.rwds_oe_l <= 1'b1;
      pins_out.cs_l      <= 1'b1;
    end else begin
      ck_loc             <= drive.ck_phase;
      pins_out.ck        <= ck_loc;
      pins_out.dq_oe_l   <= drive.dq_oe_l;
      pins_out.rwds_oe_l <= drive.rwds_oe_l;
      pins_out.cs_l      <= ~drive.cs;
    end
  end

  // No DQ drive outside a chip select window
  a_dq_in_cs: assert property (@(posedge clk) disable iff (reset)
    pins_out.cs_l |-> pins_out.dq_oe_l);

endmodule

// ==== hyper_xface.sv ====
`timescale 1ns/100ps

module hyper_xface import hyper_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  host_req_t  req,
  input  logic [7:0] latency_1x,
  input  logic [7:0] latency_2x,
  output rd_resp_t   resp,
  output logic       busy,
  input  dram_in_t   pins_in,
  output dram_out_t  pins_out,
  output logic       dram_rst_l
);

  // Between sequencer, capture and pads
  seq_drive_t      drive;
  logic            run_rd;
  logic            dword_done;
  logic            rwds_q;
  logic [DQ_W-1:0] dq_q;

  // DRAM held in reset with the core
  assign dram_rst_l = ~reset;

  hyper_cmd_seq i_hyper_cmd_seq (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .latency_1x (latency_1x),
    .latency_2x (latency_2x),
    .rwds_q     (rwds_q),
    .dword_done (dword_done),
    .busy       (busy),
    .run_rd     (run_rd),
    .drive      (drive)
  );

  hyper_rd_capture i_hyper_rd_capture (
    .clk        (clk),
    .reset      (reset),
    .run_rd     (run_rd),
    .rwds_q     (rwds_q),
    .dq_q       (dq_q),
    .dword_done (dword_done),
    .resp       (resp)
  );

  hyper_pad_stage i_hyper_pad_stage (
    .clk      (clk),
    .reset    (reset),
    .drive    (drive),
    .pins_in  (pins_in),
    .pins_out (pins_out),
    .rwds_q   (rwds_q),
    .dq_q     (dq_q)
  );

endmodule

// ==== hyperram_model.sv ====
`timescale 1ns/100ps

module hyperram_model import hyper_pkg::*; (
  input  logic      clk,
  input  dram_out_t pins_out,
  output dram_in_t  pins_in
);

  localparam int MEM_BYTES = 1024;

  // Byte wide array, register file around CR0 at 0x800
  logic [7:0]      mem [0:MEM_BYTES-1];
  logic [15:0]     regs [0:3];
  logic [CA_W-1:0] ca;
  logic [31:0]     base;
  logic [8:0]      hist [0:3];
  logic            ck_prev;
  logic            cs_prev;
  int              edges;
  event            ca_start;
  event            ca_done;

  function automatic logic [7:0] read_byte(input int k);
    logic [31:0] hw;
    hw = base + 32'(k / 2);
    if (ca[46]) begin
      // Upper byte of a half-word goes out first
      return (k % 2 == 0) ? regs[hw[1:0]][15:8] : regs[hw[1:0]][7:0];
    end
    return mem[(base * 2 + 32'(k)) % MEM_BYTES];
  endfunction

  initial begin
    for (int b = 0; b < MEM_BYTES; b++) begin
      mem[b] = 8'(b) ^ 8'(b >> 8) ^ 8'ha7;
    end
    for (int i = 0; i < 4; i++) begin
      regs[i] = 16'h0800 + 16'(i);
    end
    ck_prev = 1'b0;
    cs_prev = 1'b1;
    edges   = 0;
  end

  // ----------------------------------------------------------
  // Pin watcher, samples DQ on every CK edge
  // ----------------------------------------------------------
  always @(negedge clk) begin
    if (!pins_out.cs_l && cs_prev) begin
      edges = 0;
      -> ca_start;
    end
    if (!pins_out.cs_l && (pins_out.ck != ck_prev)) begin
      if (edges < CA_BYTES) begin
        ca = {ca[CA_W-DQ_W-1:0], pins_out.dq};
      end
      hist[3] = hist[2];
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = {pins_out.rwds, pins_out.dq};
      edges++;
      if (edges == CA_BYTES) begin
        base = {ca[44:16], ca[2:0]};
        -> ca_done;
      end
    end
    // Commit a write when chip select goes away
    if (pins_out.cs_l && !cs_prev && !ca[47] && edges > CA_BYTES) begin
      if (ca[46]) begin
        regs[base[1:0]] = {hist[1][7:0], hist[0][7:0]};
      end else begin
        for (int i = 0; i < 4; i++) begin
          // RWDS low means the byte is written
          if (!hist[3-i][8]) begin
            mem[(base * 2 + 32'(i)) % MEM_BYTES] = hist[3-i][7:0];
          end
        end
      end
    end
    ck_prev = pins_out.ck;
    cs_prev = pins_out.cs_l;
  end

  // ----------------------------------------------------------
  // Latency flag during CA, then read data with RWDS strobe
  // ----------------------------------------------------------
  initial begin
    int k;
    pins_in = '0;
    forever begin
      @(ca_start);
      @(posedge clk);
      #2;
      pins_in.rwds = 1'($urandom_range(1, 0));
      @(ca_done);
      @(posedge clk);
      #2;
      pins_in.rwds = 1'b0;
      if (ca[47]) begin
        repeat ($urandom_range(12, 1)) @(posedge clk);
        k = 0;
        while (pins_out.cs_l === 1'b0) begin
          @(posedge clk);
          #2;
          pins_in.dq   = read_byte(k);
          pins_in.rwds = ~k[0];
          @(posedge clk);
          #2;
          k++;
        end
      end else begin
        wait (pins_out.cs_l === 1'b1);
      end
      pins_in = '0;
    end
  end

endmodule

// ==== tb_hyper_xface.sv ====
`timescale 1ns/100ps

module tb_hyper_xface import hyper_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int MEM_DWORDS   = 256;
  localparam int N_FULL       = 8;
  localparam int N_MASK       = 8;
  localparam int N_MULTI      = 6;
  localparam int N_LAT        = 8;
  localparam int NUM_TXN      = 1 + 2 * N_FULL + 2 * N_MASK + N_MULTI + 2 * N_LAT + 2;

  logic       clk;
  logic       reset;
  host_req_t  req;
  logic [7:0] latency_1x;
  logic [7:0] latency_2x;
  rd_resp_t   resp;
  logic       busy;
  dram_in_t   pins_in;
  dram_out_t  pins_out;
  logic       dram_rst_l;

  // Reference contents in DRAM byte order
  logic [7:0]         ref_mem [0:4*MEM_DWORDS-1];
  logic [DWORD_W-1:0] exp_q[$];

  hyper_xface i_hyper_xface (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .latency_1x (latency_1x),
    .latency_2x (latency_2x),
    .resp       (resp),
    .busy       (busy),
    .pins_in    (pins_in),
    .pins_out   (pins_out),
    .dram_rst_l (dram_rst_l)
  );

  hyperram_model i_hyperram_model (
    .clk      (clk),
    .pins_out (pins_out),
    .pins_in  (pins_in)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------------------------
  // Reporting and compares
  // ----------------------------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_resp(input string name, input rd_resp_t exp, input rd_resp_t act);
    if (act.data !== exp.data) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, exp.data, act.data));
    end
  endtask

  // Idle control pins only
  task automatic check_pins(input string name, input dram_out_t exp, input dram_out_t act);
    if ({act.cs_l, act.dq_oe_l, act.rwds_oe_l, act.ck} !==
        {exp.cs_l, exp.dq_oe_l, exp.rwds_oe_l, exp.ck}) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic logic [7:0] fill_byte(input int b);
    return 8'(b) ^ 8'(b >> 8) ^ 8'ha7;
  endfunction

  function automatic logic [DWORD_W-1:0] ref_dword(input int a);
    return {ref_mem[4*a], ref_mem[4*a+1], ref_mem[4*a+2], ref_mem[4*a+3]};
  endfunction

  // ----------------------------------------------------------
  // Host side transactions
  // ----------------------------------------------------------
  task automatic send_req(input host_req_t r);
    @(posedge clk);
    #2;
    req = r;
    @(posedge clk);
    #2;
    req = '0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (busy);
  endtask

  // Compares every rd_rdy against exp_q until busy drops
  task automatic collect_reads(input string name, input host_req_t r);
    rd_resp_t exp;
    send_req(r);
    do begin
      @(negedge clk);
      if (resp.rdy) begin
        if (exp_q.size() == 0) begin
          stop_run($sformatf("%s: rd_rdy pulsed more often than requested", name));
        end
        exp.rdy  = 1'b1;
        exp.data = exp_q.pop_front();
        check_resp(name, exp, resp);
      end
    end while (busy);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%s: read ended with %0d dwords missing", name, exp_q.size()));
    end
  endtask

  task automatic read_mem(input string name, input int a, input int n);
    host_req_t r;
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(ref_dword(a + k));
    end
    r            = '0;
    r.rd         = 1'b1;
    r.num_dwords = NUM_DWORDS_W'(n);
    r.addr       = host_addr_u'(32'(a));
    collect_reads(name, r);
  endtask

  task automatic write_mem(input int a, input logic [31:0] d, input logic [3:0] be);
    host_req_t r;
    r         = '0;
    r.wr      = 1'b1;
    r.byte_en = be;
    r.addr    = host_addr_u'(32'(a));
    r.wr_d    = d;
    send_req(r);
    wait_idle();
    // byte_en[3] enables the first byte wr_d[31:24]
    for (int i = 0; i < 4; i++) begin
      if (be[3-i]) begin
        ref_mem[4*a+i] = d[31-8*i -: 8];
      end
    end
  endtask

  // Hang guard
  initial begin
    #((NUM_TXN * 300 + RESET_CYCLES + RESET_WAIT) * CLK_PERIOD);
    stop_run("timeout: the tests did not finish in the allowed time");
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    dram_out_t   idle;
    host_req_t   r;
    logic [31:0] d;
    int          a;
    int          n;
    void'($urandom(88861));
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    latency_1x = 8'd4;
    latency_2x = 8'd10;
    for (int b = 0; b < 4 * MEM_DWORDS; b++) begin
      ref_mem[b] = fill_byte(b);
    end
    repeat (RESET_CYCLES - 1) @(posedge clk);
    // DRAM reset follows the core reset
    @(negedge clk);
    check_level("reset_dram_rst_l", 1'b0, dram_rst_l);
    @(posedge clk);
    #2;
    reset = 1'b0;

    // Idle pins and DRAM reset release
    @(negedge clk);
    idle           = '0;
    idle.cs_l      = 1'b1;
    idle.dq_oe_l   = 1'b1;
    idle.rwds_oe_l = 1'b1;
    check_pins("reset_pins", idle, pins_out);
    check_level("reset_busy", 1'b0, busy);
    check_level("reset_rd_rdy", 1'b0, resp.rdy);
    check_level("run_dram_rst_l", 1'b1, dram_rst_l);
    // Read issued inside the tRH wait
    read_mem("read_in_reset_wait", $urandom_range(MEM_DWORDS - 1, 0), 1);

    for (int i = 0; i < N_FULL; i++) begin
      a = $urandom_range(MEM_DWORDS - 1, 0);
      write_mem(a, $urandom, 4'hf);
      read_mem("full_write", a, 1);
    end

    for (int i = 0; i < N_MASK; i++) begin
      a = $urandom_range(MEM_DWORDS - 1, 0);
      write_mem(a, $urandom, 4'($urandom_range(15, 0)));
      read_mem("byte_enable_write", a, 1);
    end

    for (int i = 0; i < N_MULTI; i++) begin
      n = $urandom_range(8, 1);
      read_mem("multi_dword_read", $urandom_range(MEM_DWORDS - 8, 0), n);
    end

    // Model picks 1x or 2x per transaction
    for (int i = 0; i < N_LAT; i++) begin
      a = $urandom_range(MEM_DWORDS - 1, 0);
      write_mem(a, $urandom, 4'hf);
      read_mem("latency_write", a, 1);
    end

    // CR0 write and read back of 0x800 and 0x801
    d           = $urandom;
    r           = '0;
    r.wr        = 1'b1;
    r.reg_space = 1'b1;
    r.addr      = host_addr_u'(32'h0000_0800);
    r.wr_d      = d;
    send_req(r);
    wait_idle();
    r.wr         = 1'b0;
    r.rd         = 1'b1;
    r.num_dwords = NUM_DWORDS_W'(1);
    exp_q.delete();
    exp_q.push_back({d[31:16], 16'h0801});
    collect_reads("register_read", r);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
hyper_pkg.sv
hyper_cmd_seq.sv
hyper_rd_capture.sv
hyper_pad_stage.sv
hyper_xface.sv
hyperram_model.sv
tb_hyper_xface.sv
